// ==== hw/rs_defines.svh ====
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// data and pc word width
`define XLEN 32

// reorder tag width, 16 tags in flight
`define TAG_W 4

// entries in each reservation station
`define RS_DEPTH 4

// next pc step for a not-taken branch
`define PC_STEP 4

`endif

// ==== hw/core_types_pkg.sv ====
`default_nettype none

`include "rs_defines.svh"

package core_types_pkg;

    // one data or pc word
    typedef logic [`XLEN-1:0] word_t;

    // reorder buffer tag
    typedef logic [`TAG_W-1:0] tag_t;

    // source operand slot
    // valid set means value holds the operand, else wait for tag on the cdb
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } operand_t;

endpackage

`default_nettype wire

// ==== hw/exec_ops_pkg.sv ====
`default_nettype none

package exec_ops_pkg;

    import core_types_pkg::*;

    // compare and branch opcodes
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'd0,
        CMP_BNE  = 3'd1,
        CMP_BLT  = 3'd2,
        CMP_BGE  = 3'd3,
        CMP_BLTU = 3'd4,
        CMP_BGEU = 3'd5,
        CMP_SLT  = 3'd6,
        CMP_SLTU = 3'd7
    } cmp_op_t;

    // simple alu opcodes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SRA = 3'd7
    } alu_op_t;

    // compare station payload, pc and imm only matter for branches
    typedef struct packed {
        cmp_op_t op;
        logic    branch;
        word_t   pc;
        word_t   imm;
    } cmp_payload_t;

    typedef struct packed {
        alu_op_t op;
    } alu_payload_t;

endpackage

`default_nettype wire

// ==== hw/rs_station.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rs_defines.svh"

module rs_station #(
    parameter type payload_t = core_types_pkg::word_t
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     flush_i,
    input  logic                     disp_i,
    input  core_types_pkg::tag_t     disp_tag_i,
    input  core_types_pkg::operand_t disp_src1_i,
    input  core_types_pkg::operand_t disp_src2_i,
    input  payload_t                 disp_pl_i,
    input  logic                     cdb_valid_i,
    input  core_types_pkg::tag_t     cdb_tag_i,
    input  core_types_pkg::word_t    cdb_value_i,
    input  logic                     unit_busy_i,
    output logic                     full_o,
    output logic                     issue_o,
    output core_types_pkg::word_t    issue_a_o,
    output core_types_pkg::word_t    issue_b_o,
    output core_types_pkg::tag_t     issue_tag_o,
    output payload_t                 issue_pl_o
);

    import core_types_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    // entry state
    logic [`RS_DEPTH-1:0] ent_valid;
    tag_t                 ent_tag  [`RS_DEPTH];
    operand_t             ent_src1 [`RS_DEPTH];
    operand_t             ent_src2 [`RS_DEPTH];
    payload_t             ent_pl   [`RS_DEPTH];

    logic [`RS_DEPTH-1:0] ent_ready;
    logic [IDX_W-1:0]     alloc_idx;
    logic [IDX_W-1:0]     issue_idx;
    logic                 alloc_ok;
    logic                 issue_found;

    // capture a waiting operand when its tag is on the bus
    function automatic operand_t snoop(input operand_t src, input logic bus_valid,
                                       input tag_t bus_tag, input word_t bus_value);
        operand_t res;
        res = src;
        if (!src.valid && bus_valid && (src.tag == bus_tag)) begin
            res.valid = 1'b1;
            res.value = bus_value;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ent_ready[i] = ent_valid[i] & ent_src1[i].valid & ent_src2[i].valid;
        end
    end

    // lowest free entry and lowest ready entry
    // scan from the top so the lowest index is left standing
    always_comb begin
        alloc_ok    = 1'b0;
        alloc_idx   = '0;
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                alloc_ok  = 1'b1;
                alloc_idx = IDX_W'(i);
            end
            if (ent_ready[i]) begin
                issue_found = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    assign full_o      = &ent_valid;
    assign issue_o     = issue_found & ~unit_busy_i;
    assign issue_a_o   = ent_src1[issue_idx].value;
    assign issue_b_o   = ent_src2[issue_idx].value;
    assign issue_tag_o = ent_tag[issue_idx];
    assign issue_pl_o  = ent_pl[issue_idx];

    // occupancy
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ent_valid <= '0;
        end else begin
            if (issue_o) begin
                ent_valid[issue_idx] <= 1'b0;
            end
            if (disp_i && alloc_ok) begin
                ent_valid[alloc_idx] <= 1'b1;
            end
        end
    end

    // operand snooping, then the new entry overrides its own slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ent_src1[i] <= snoop(ent_src1[i], cdb_valid_i, cdb_tag_i, cdb_value_i);
            ent_src2[i] <= snoop(ent_src2[i], cdb_valid_i, cdb_tag_i, cdb_value_i);
        end
        if (disp_i && alloc_ok) begin
            ent_tag[alloc_idx]  <= disp_tag_i;
            ent_pl[alloc_idx]   <= disp_pl_i;
            ent_src1[alloc_idx] <= snoop(disp_src1_i, cdb_valid_i, cdb_tag_i, cdb_value_i);
            ent_src2[alloc_idx] <= snoop(disp_src2_i, cdb_valid_i, cdb_tag_i, cdb_value_i);
        end
    end

endmodule

`default_nettype wire

// ==== hw/cmp_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rs_defines.svh"

module cmp_unit (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        flush_i,
    input  logic                        issue_i,
    input  core_types_pkg::word_t       a_i,
    input  core_types_pkg::word_t       b_i,
    input  core_types_pkg::tag_t        tag_i,
    input  exec_ops_pkg::cmp_payload_t  pl_i,
    input  logic                        grant_i,
    output logic                        busy_o,
    output logic                        req_o,
    output core_types_pkg::tag_t        res_tag_o,
    output core_types_pkg::word_t       res_value_o,
    output core_types_pkg::word_t       res_pc_o,
    output logic                        res_branch_o
);

    import core_types_pkg::*;
    import exec_ops_pkg::*;

    logic  cmp_true;
    word_t next_pc;
    logic  res_valid;

    always_comb begin
        cmp_true = 1'b0;
        case (pl_i.op)
            CMP_BEQ:  cmp_true = (a_i == b_i);
            CMP_BNE:  cmp_true = (a_i != b_i);
            CMP_BLT:  cmp_true = ($signed(a_i) < $signed(b_i));
            CMP_BGE:  cmp_true = ($signed(a_i) >= $signed(b_i));
            CMP_BLTU: cmp_true = (a_i < b_i);
            CMP_BGEU: cmp_true = (a_i >= b_i);
            CMP_SLT:  cmp_true = ($signed(a_i) < $signed(b_i));
            CMP_SLTU: cmp_true = (a_i < b_i);
            default:  cmp_true = 1'b0;
        endcase
    end

    // taken target or fall-through, zero for set-less-than
    assign next_pc = !pl_i.branch ? word_t'(0) :
                     cmp_true     ? pl_i.pc + pl_i.imm :
                                    pl_i.pc + word_t'(`PC_STEP);

    // result held until the bus is granted
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            res_valid <= 1'b0;
        end else if (issue_i) begin
            res_valid <= 1'b1;
        end else if (grant_i) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            res_tag_o    <= tag_i;
            res_value_o  <= {{(`XLEN - 1){1'b0}}, cmp_true};
            res_pc_o     <= next_pc;
            res_branch_o <= pl_i.branch;
        end
    end

    assign busy_o = res_valid;
    assign req_o  = res_valid;

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu_unit (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        flush_i,
    input  logic                        issue_i,
    input  core_types_pkg::word_t       a_i,
    input  core_types_pkg::word_t       b_i,
    input  core_types_pkg::tag_t        tag_i,
    input  exec_ops_pkg::alu_payload_t  pl_i,
    input  logic                        grant_i,
    output logic                        busy_o,
    output logic                        req_o,
    output core_types_pkg::tag_t        res_tag_o,
    output core_types_pkg::word_t       res_value_o
);

    import core_types_pkg::*;
    import exec_ops_pkg::*;

    word_t alu_res;
    logic  res_valid;

    // shift amount from low five bits of b
    always_comb begin
        case (pl_i.op)
            ALU_ADD: alu_res = a_i + b_i;
            ALU_SUB: alu_res = a_i - b_i;
            ALU_AND: alu_res = a_i & b_i;
            ALU_OR:  alu_res = a_i | b_i;
            ALU_XOR: alu_res = a_i ^ b_i;
            ALU_SLL: alu_res = a_i << b_i[4:0];
            ALU_SRL: alu_res = a_i >> b_i[4:0];
            ALU_SRA: alu_res = word_t'($signed(a_i) >>> b_i[4:0]);
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            res_valid <= 1'b0;
        end else if (issue_i) begin
            res_valid <= 1'b1;
        end else if (grant_i) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            res_tag_o   <= tag_i;
            res_value_o <= alu_res;
        end
    end

    assign busy_o = res_valid;
    assign req_o  = res_valid;

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  cmp_req_i,
    input  core_types_pkg::tag_t  cmp_tag_i,
    input  core_types_pkg::word_t cmp_value_i,
    input  core_types_pkg::word_t cmp_pc_i,
    input  logic                  cmp_branch_i,
    input  logic                  alu_req_i,
    input  core_types_pkg::tag_t  alu_tag_i,
    input  core_types_pkg::word_t alu_value_i,
    output logic                  cmp_grant_o,
    output logic                  alu_grant_o,
    output logic                  cdb_valid_o,
    output core_types_pkg::tag_t  cdb_tag_o,
    output core_types_pkg::word_t cdb_value_o,
    output core_types_pkg::word_t cdb_pc_o,
    output logic                  cdb_branch_o
);

    import core_types_pkg::*;

    // set when the alu unit took the last grant
    logic last_alu;

    // lone requester wins, a tie goes to whoever lost last time
    assign cmp_grant_o = cmp_req_i & (~alu_req_i | last_alu);
    assign alu_grant_o = alu_req_i & (~cmp_req_i | ~last_alu);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            last_alu <= 1'b0;
        end else if (cmp_grant_o || alu_grant_o) begin
            last_alu <= alu_grant_o;
        end
    end

    // bus mux
    assign cdb_valid_o  = cmp_grant_o | alu_grant_o;
    assign cdb_tag_o    = alu_grant_o ? alu_tag_i : cmp_tag_i;
    assign cdb_value_o  = alu_grant_o ? alu_value_i : cmp_value_i;
    assign cdb_pc_o     = cmp_grant_o ? cmp_pc_i : word_t'(0);
    assign cdb_branch_o = cmp_grant_o & cmp_branch_i;

endmodule

`default_nettype wire

// ==== hw/exec_cluster_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module exec_cluster_top (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       flush_i,
    input  logic                       disp_cmp_i,
    input  logic                       disp_alu_i,
    input  core_types_pkg::tag_t       disp_tag_i,
    input  core_types_pkg::operand_t   disp_src1_i,
    input  core_types_pkg::operand_t   disp_src2_i,
    input  exec_ops_pkg::cmp_payload_t disp_cmp_pl_i,
    input  exec_ops_pkg::alu_payload_t disp_alu_pl_i,
    output logic                       cmp_full_o,
    output logic                       alu_full_o,
    output logic                       cdb_valid_o,
    output core_types_pkg::tag_t       cdb_tag_o,
    output core_types_pkg::word_t      cdb_value_o,
    output core_types_pkg::word_t      cdb_pc_o,
    output logic                       cdb_branch_o
);

    import core_types_pkg::*;
    import exec_ops_pkg::*;

    // compare path
    logic         cmp_issue;
    word_t        cmp_a;
    word_t        cmp_b;
    tag_t         cmp_issue_tag;
    cmp_payload_t cmp_issue_pl;
    logic         cmp_busy;
    logic         cmp_req;
    logic         cmp_grant;
    tag_t         cmp_res_tag;
    word_t        cmp_res_value;
    word_t        cmp_res_pc;
    logic         cmp_res_branch;

    // alu path
    logic         alu_issue;
    word_t        alu_a;
    word_t        alu_b;
    tag_t         alu_issue_tag;
    alu_payload_t alu_issue_pl;
    logic         alu_busy;
    logic         alu_req;
    logic         alu_grant;
    tag_t         alu_res_tag;
    word_t        alu_res_value;

    rs_station #(
        .payload_t (cmp_payload_t)
    ) u_cmp_rs (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .disp_i      (disp_cmp_i),
        .disp_tag_i  (disp_tag_i),
        .disp_src1_i (disp_src1_i),
        .disp_src2_i (disp_src2_i),
        .disp_pl_i   (disp_cmp_pl_i),
        .cdb_valid_i (cdb_valid_o),
        .cdb_tag_i   (cdb_tag_o),
        .cdb_value_i (cdb_value_o),
        .unit_busy_i (cmp_busy),
        .full_o      (cmp_full_o),
        .issue_o     (cmp_issue),
        .issue_a_o   (cmp_a),
        .issue_b_o   (cmp_b),
        .issue_tag_o (cmp_issue_tag),
        .issue_pl_o  (cmp_issue_pl)
    );

    rs_station #(
        .payload_t (alu_payload_t)
    ) u_alu_rs (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .disp_i      (disp_alu_i),
        .disp_tag_i  (disp_tag_i),
        .disp_src1_i (disp_src1_i),
        .disp_src2_i (disp_src2_i),
        .disp_pl_i   (disp_alu_pl_i),
        .cdb_valid_i (cdb_valid_o),
        .cdb_tag_i   (cdb_tag_o),
        .cdb_value_i (cdb_value_o),
        .unit_busy_i (alu_busy),
        .full_o      (alu_full_o),
        .issue_o     (alu_issue),
        .issue_a_o   (alu_a),
        .issue_b_o   (alu_b),
        .issue_tag_o (alu_issue_tag),
        .issue_pl_o  (alu_issue_pl)
    );

    cmp_unit u_cmp_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .issue_i      (cmp_issue),
        .a_i          (cmp_a),
        .b_i          (cmp_b),
        .tag_i        (cmp_issue_tag),
        .pl_i         (cmp_issue_pl),
        .grant_i      (cmp_grant),
        .busy_o       (cmp_busy),
        .req_o        (cmp_req),
        .res_tag_o    (cmp_res_tag),
        .res_value_o  (cmp_res_value),
        .res_pc_o     (cmp_res_pc),
        .res_branch_o (cmp_res_branch)
    );

    alu_unit u_alu_unit (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .issue_i     (alu_issue),
        .a_i         (alu_a),
        .b_i         (alu_b),
        .tag_i       (alu_issue_tag),
        .pl_i        (alu_issue_pl),
        .grant_i     (alu_grant),
        .busy_o      (alu_busy),
        .req_o       (alu_req),
        .res_tag_o   (alu_res_tag),
        .res_value_o (alu_res_value)
    );

    // single shared result bus
    cdb_arbiter u_cdb_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .cmp_req_i    (cmp_req),
        .cmp_tag_i    (cmp_res_tag),
        .cmp_value_i  (cmp_res_value),
        .cmp_pc_i     (cmp_res_pc),
        .cmp_branch_i (cmp_res_branch),
        .alu_req_i    (alu_req),
        .alu_tag_i    (alu_res_tag),
        .alu_value_i  (alu_res_value),
        .cmp_grant_o  (cmp_grant),
        .alu_grant_o  (alu_grant),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o),
        .cdb_pc_o     (cdb_pc_o),
        .cdb_branch_o (cdb_branch_o)
    );

endmodule

`default_nettype wire

// ==== verification/exec_cluster_assert.sv ====
`default_nettype none
`timescale 1ns/100ps

module exec_cluster_assert (
    input logic clk,
    input logic rst_i,
    input logic flush_i,
    input logic disp_cmp_i,
    input logic disp_alu_i,
    input logic cmp_full_i,
    input logic alu_full_i,
    input logic cmp_grant_i,
    input logic alu_grant_i,
    input logic cdb_valid_i
);

    // dispatcher has to respect the full flags
    a_disp_not_full: assert property (@(posedge clk) disable iff (rst_i)
        !(disp_cmp_i && cmp_full_i) && !(disp_alu_i && alu_full_i))
        else $error("dispatch to a full reservation station");

    a_one_disp: assert property (@(posedge clk) disable iff (rst_i)
        !(disp_cmp_i && disp_alu_i))
        else $error("both dispatch strobes high in one cycle");

    // one bus, one winner
    a_one_grant: assert property (@(posedge clk) disable iff (rst_i)
        !(cmp_grant_i && alu_grant_i))
        else $error("both units granted the bus in one cycle");

    a_quiet_after_reset: assert property (@(posedge clk)
        rst_i |=> !cdb_valid_i)
        else $error("bus valid in the cycle after reset");

    a_quiet_after_flush: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> !cdb_valid_i)
        else $error("bus valid in the cycle after flush");

endmodule

bind exec_cluster_top exec_cluster_assert u_cluster_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .disp_cmp_i  (disp_cmp_i),
    .disp_alu_i  (disp_alu_i),
    .cmp_full_i  (cmp_full_o),
    .alu_full_i  (alu_full_o),
    .cmp_grant_i (cmp_grant),
    .alu_grant_i (alu_grant),
    .cdb_valid_i (cdb_valid_o)
);

`default_nettype wire

// ==== verification/exec_cluster_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rs_defines.svh"

module exec_cluster_tb;

    import core_types_pkg::*;
    import exec_ops_pkg::*;

    localparam int NTAGS = 1 << `TAG_W;

    logic         clk;
    logic         rst_i;
    logic         flush_i;
    logic         disp_cmp_i;
    logic         disp_alu_i;
    tag_t         disp_tag_i;
    operand_t     disp_src1_i;
    operand_t     disp_src2_i;
    cmp_payload_t disp_cmp_pl_i;
    alu_payload_t disp_alu_pl_i;
    logic         cmp_full_o;
    logic         alu_full_o;
    logic         cdb_valid_o;
    tag_t         cdb_tag_o;
    word_t        cdb_value_o;
    word_t        cdb_pc_o;
    logic         cdb_branch_o;

    // model: one row per tag, value known at dispatch time
    logic  in_flight  [NTAGS];
    word_t tag_value  [NTAGS];
    word_t tag_pc     [NTAGS];
    logic  tag_branch [NTAGS];

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     err_start;

    exec_cluster_top dut_i (.*);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        int    sh;
        word_t fill;
        sh   = int'(b[4:0]);
        // sign bits shifted in from the top for an arithmetic shift
        fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + word_t'(1);
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            default: return (a >> sh) | fill;
        endcase
    endfunction

    function automatic logic model_cmp(input cmp_op_t op, input word_t a, input word_t b);
        word_t sa;
        word_t sb;
        // flipped sign bit turns a signed order into an unsigned one
        sa = a ^ (word_t'(1) << (`XLEN - 1));
        sb = b ^ (word_t'(1) << (`XLEN - 1));
        case (op)
            CMP_BEQ:           return a == b;
            CMP_BNE:           return a != b;
            CMP_BLT, CMP_SLT:  return sa < sb;
            CMP_BGE:           return !(sa < sb);
            CMP_BLTU, CMP_SLTU: return a < b;
            default:           return !(a < b);
        endcase
    endfunction

    // random tag with the wanted in-flight state
    function automatic logic find_tag(input logic busy, output tag_t t);
        int start;
        start = rand_below(NTAGS);
        t = '0;
        for (int i = 0; i < NTAGS; i++) begin
            if (in_flight[tag_t'(start + i)] == busy) begin
                t = tag_t'(start + i);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int count_in_flight();
        int c;
        c = 0;
        for (int i = 0; i < NTAGS; i++) begin
            c += int'(in_flight[i]);
        end
        return c;
    endfunction

    function automatic operand_t wait_on(input tag_t t);
        operand_t s;
        s.valid = 1'b0;
        s.tag   = t;
        s.value = rand_word();
        return s;
    endfunction

    function automatic operand_t done_src(input tag_t t);
        operand_t s;
        s.valid = 1'b1;
        s.tag   = t;
        s.value = tag_value[t];
        return s;
    endfunction

    // waits only if the producer has not been seen on the bus yet
    function automatic operand_t link_src(input tag_t t);
        return in_flight[t] ? wait_on(t) : done_src(t);
    endfunction

    function automatic operand_t pick_source(input int wait_pct);
        tag_t t;
        if (rand_below(100) < wait_pct && find_tag(1'b1, t)) begin
            return wait_on(t);
        end
        void'(find_tag(1'b0, t));
        return done_src(t);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic observe_bus();
        tag_t t;
        if (cdb_valid_o) begin
            t = cdb_tag_o;
            if (!in_flight[t]) begin
                $display("ERROR: bus carried tag 0x%h, which has no work in flight", t);
                errors++;
            end else begin
                check_word("cdb_value_o", cdb_value_o, tag_value[t]);
                check_word("cdb_pc_o", cdb_pc_o, tag_pc[t]);
                check_word("cdb_branch_o", word_t'(cdb_branch_o), word_t'(tag_branch[t]));
                in_flight[t] = 1'b0;
            end
        end
    endtask

    // bus of the ending cycle is recorded before the edge
    task automatic next_cycle();
        observe_bus();
        @(posedge clk);
        #1;
        disp_cmp_i = 1'b0;
        disp_alu_i = 1'b0;
        flush_i    = 1'b0;
    endtask

    task automatic wait_not_full(input logic to_cmp);
        int n;
        n = 0;
        while ((to_cmp ? cmp_full_o : alu_full_o) && n < 100) begin
            next_cycle();
            n++;
        end
        if (to_cmp ? cmp_full_o : alu_full_o) begin
            $display("ERROR: station stayed full for 100 cycles while dispatch waited");
            errors++;
        end
    endtask

    task automatic send_op(input logic to_cmp, input operand_t s1, input operand_t s2,
                           output tag_t t);
        word_t        a;
        word_t        b;
        logic         hit;
        cmp_payload_t cpl;
        alu_payload_t apl;
        a = s1.valid ? s1.value : tag_value[s1.tag];
        b = s2.valid ? s2.value : tag_value[s2.tag];
        void'(find_tag(1'b0, t));
        disp_tag_i  = t;
        disp_src1_i = s1;
        disp_src2_i = s2;
        if (to_cmp) begin
            cpl.op        = cmp_op_t'(rand_below(8));
            cpl.branch    = (cpl.op != CMP_SLT) && (cpl.op != CMP_SLTU);
            cpl.pc        = rand_word() & ~word_t'(3);
            cpl.imm       = word_t'(rand_below(8192) - 4096) & ~word_t'(1);
            hit           = model_cmp(cpl.op, a, b);
            tag_value[t]  = word_t'(hit);
            tag_pc[t]     = !cpl.branch ? '0 :
                            hit         ? cpl.pc + cpl.imm :
                                          cpl.pc + word_t'(`PC_STEP);
            tag_branch[t] = cpl.branch;
            disp_cmp_pl_i = cpl;
            disp_cmp_i    = 1'b1;
        end else begin
            apl.op        = alu_op_t'(rand_below(8));
            tag_value[t]  = model_alu(apl.op, a, b);
            tag_pc[t]     = '0;
            tag_branch[t] = 1'b0;
            disp_alu_pl_i = apl;
            disp_alu_i    = 1'b1;
        end
        in_flight[t] = 1'b1;
    endtask

    // one op on an idle cluster, its tag must be the next one on the bus
    task automatic single_op(input logic to_cmp);
        tag_t t;
        int   n;
        send_op(to_cmp, pick_source(0), pick_source(0), t);
        next_cycle();
        n = 0;
        while (!cdb_valid_o && n < 20) begin
            next_cycle();
            n++;
        end
        if (!cdb_valid_o) begin
            $display("ERROR: no bus result for tag 0x%h within 20 cycles", t);
            errors++;
        end else begin
            check_tag("cdb_tag_o", cdb_tag_o, t);
        end
    endtask

    task automatic run_random(input int n, input int cmp_pct, input int wait_pct,
                              input int same_pct);
        logic     to_cmp;
        operand_t s1;
        operand_t s2;
        tag_t     t;
        for (int i = 0; i < n; i++) begin
            to_cmp = rand_below(100) < cmp_pct;
            wait_not_full(to_cmp);
            s1 = pick_source(wait_pct);
            s2 = (rand_below(100) < same_pct) ? s1 : pick_source(wait_pct);
            send_op(to_cmp, s1, s2, t);
            next_cycle();
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (count_in_flight() > 0 && n < 500) begin
            next_cycle();
            n++;
        end
        if (count_in_flight() > 0) begin
            $display("ERROR: %0d tags still not completed after 500 cycles",
                     count_in_flight());
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s FAILED with %0d errors", name, errors - err_start);
        end
        err_start = errors;
    endtask

    // compare station fills up behind a long alu chain
    task automatic load_stations();
        tag_t t;
        tag_t u;
        // six dependent alu ops keep the last tag busy for about a dozen cycles
        wait_not_full(1'b0);
        send_op(1'b0, pick_source(0), pick_source(0), t);
        next_cycle();
        for (int i = 0; i < 5; i++) begin
            wait_not_full(1'b0);
            send_op(1'b0, link_src(t), pick_source(0), t);
            next_cycle();
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wait_not_full(1'b1);
            send_op(1'b1, link_src(t), pick_source(0), u);
            next_cycle();
        end
        if (!cmp_full_o) begin
            $display("ERROR: cmp_full_o stayed low with every compare entry taken");
            errors++;
        end
    endtask

    task automatic fill_station();
        load_stations();
        drain();
        if (cmp_full_o || alu_full_o) begin
            $display("ERROR: a full flag is still high after both stations drained");
            errors++;
        end
    endtask

    task automatic flush_outstanding();
        load_stations();
        flush_i = 1'b1;
        next_cycle();
        // whatever was still pending is gone, a later broadcast of it is an error
        for (int i = 0; i < NTAGS; i++) begin
            in_flight[i] = 1'b0;
        end
        if (cmp_full_o || alu_full_o) begin
            $display("ERROR: a full flag is high after the flush");
            errors++;
        end
        for (int i = 0; i < 20; i++) begin
            next_cycle();
        end
        run_random(40, 50, 40, 10);
        drain();
    endtask

    initial begin
        seed          = 32'hdf6e_3abc;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        err_start     = 0;
        rst_i         = 1'b1;
        flush_i       = 1'b0;
        disp_cmp_i    = 1'b0;
        disp_alu_i    = 1'b0;
        disp_tag_i    = '0;
        disp_src1_i   = '0;
        disp_src2_i   = '0;
        disp_cmp_pl_i = '0;
        disp_alu_pl_i = '0;
        // every tag starts completed with some register value
        for (int i = 0; i < NTAGS; i++) begin
            in_flight[i]  = 1'b0;
            tag_value[i]  = rand_word();
            tag_pc[i]     = '0;
            tag_branch[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;

        for (int i = 0; i < 8; i++) begin
            single_op(1'b0);
        end
        run_random(40, 0, 0, 0);
        drain();
        finish_test("alu_indep");

        for (int i = 0; i < 8; i++) begin
            single_op(1'b1);
        end
        run_random(60, 100, 0, 25);
        drain();
        finish_test("cmp_branch");

        run_random(120, 50, 60, 10);
        drain();
        finish_test("dep_chain");

        fill_station();
        finish_test("station_fill");

        // alternating stations keep both units asking for the bus
        for (int i = 0; i < 40; i++) begin
            wait_not_full(i[0]);
            run_random(1, i[0] ? 100 : 0, 20, 0);
        end
        drain();
        finish_test("bus_contention");

        flush_outstanding();
        finish_test("flush");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #500000;
        $display("ERROR: simulation ran past its time limit");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/core_types_pkg.sv
hw/exec_ops_pkg.sv
hw/rs_station.sv
hw/cmp_unit.sv
hw/alu_unit.sv
hw/cdb_arbiter.sv
hw/exec_cluster_top.sv
verification/exec_cluster_assert.sv
verification/exec_cluster_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vexec_cluster_tb
SRCS := $(wildcard hw/*.sv hw/*.svh verification/*.sv) vlog.f

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --assert -j 0 --top-module exec_cluster_tb -f vlog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
